/* source/rv_core_pkg.sv */
`default_nettype none

/* shared widths, RV64I major opcodes and decode types for the single-cycle core
   only the opcodes the core executes are listed; others retire as no-ops */

package rv_core_pkg;

  localparam int unsigned XLEN = 64;
  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_OP_IMM    = 7'h13;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'h1b;
  localparam logic [6:0] OPC_OP        = 7'h33;
  localparam logic [6:0] OPC_OP_32     = 7'h3b;
  localparam logic [6:0] OPC_LUI       = 7'h37;
  localparam logic [6:0] OPC_AUIPC     = 7'h17;
  localparam logic [6:0] OPC_JAL       = 7'h6f;
  localparam logic [6:0] OPC_JALR      = 7'h67;
  localparam logic [6:0] OPC_BRANCH    = 7'h63;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_op_e;

  // decode result, consumed by exe, pc and writeback
  typedef struct packed {
    logic    rd_w_ena;
    logic [4:0] rd_w_addr;
    alu_op_e alu_op;
    logic    is_word_opt;
    br_op_e  br_op;
    logic    is_jal;
    logic    is_jalr;
  } dec_ctrl_t;

  // register writeback port
  typedef struct packed {
    logic            ena;
    logic [4:0]      addr;
    logic [XLEN-1:0] data;
  } wb_t;

endpackage

`default_nettype wire

/* source/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

/* decodes one RV64I instruction; loads, stores, fence and system give no write
   only rd_w_ena, br_op and the jump flags are qualified by inst_valid */

module id_stage (
  input  logic [31:0]                  inst,
  input  logic                         inst_valid,
  input  logic [rv_core_pkg::XLEN-1:0] inst_addr,
  input  logic [rv_core_pkg::XLEN-1:0] r_data1,
  input  logic [rv_core_pkg::XLEN-1:0] r_data2,
  output logic [4:0]                   rs1_r_addr,
  output logic [4:0]                   rs2_r_addr,
  output rv_core_pkg::dec_ctrl_t       ctrl,
  output logic [rv_core_pkg::XLEN-1:0] exe_op1,
  output logic [rv_core_pkg::XLEN-1:0] exe_op2,
  output logic [rv_core_pkg::XLEN-1:0] jmp_imm,
  output logic [rv_core_pkg::XLEN-1:0] jalr_target
);
  import rv_core_pkg::*;

  logic [6:0]      opcode;
  logic [4:0]      rd;
  logic [2:0]      func3;
  logic [6:0]      func7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic            is_op_imm;
  logic            is_op_imm_32;
  logic            is_op;
  logic            is_op_32;
  logic            is_lui;
  logic            is_auipc;
  logic            is_jal;
  logic            is_jalr;
  logic            is_branch;
  logic            r_funct_ok;
  logic            word_f3_ok;
  logic            imm64_ok;
  logic            supported;
  alu_op_e         alu_op;
  br_op_e          br_op;
  logic [XLEN-1:0] jalr_sum;

  assign opcode     = inst[6:0];
  assign rd         = inst[11:7];
  assign func3      = inst[14:12];
  assign func7      = inst[31:25];
  assign rs1_r_addr = inst[19:15];
  assign rs2_r_addr = inst[24:20];

  // immediates, all sign extended to 64 bits
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign is_op_imm    = (opcode == OPC_OP_IMM);
  assign is_op_imm_32 = (opcode == OPC_OP_IMM_32);
  assign is_op        = (opcode == OPC_OP);
  assign is_op_32     = (opcode == OPC_OP_32);
  assign is_lui       = (opcode == OPC_LUI);
  assign is_auipc     = (opcode == OPC_AUIPC);
  assign is_jal       = (opcode == OPC_JAL);
  assign is_jalr      = (opcode == OPC_JALR) && (func3 == 3'd0);
  assign is_branch    = (opcode == OPC_BRANCH);

  // func7 is 0x00, or 0x20 for sub and sra only
  assign r_funct_ok = (func7 == 7'h00) ||
                      ((func7 == 7'h20) && ((func3 == 3'd0) || (func3 == 3'd5)));
  assign word_f3_ok = (func3 == 3'd0) || (func3 == 3'd1) || (func3 == 3'd5);
  // 64-bit shift immediates carry a 6-bit shamt, so only inst[31:26] is checked
  assign imm64_ok   = (func3 == 3'd1) ? (inst[31:26] == 6'h00) :
                      (func3 == 3'd5) ? ((inst[31:26] == 6'h00) || (inst[31:26] == 6'h10)) :
                      1'b1;

  // mul/div encodings and odd func fields fall out here
  assign supported = (is_op_imm && imm64_ok) || (is_op && r_funct_ok) ||
                     (is_op_32 && r_funct_ok && word_f3_ok) ||
                     (is_op_imm_32 && word_f3_ok && ((func3 == 3'd0) || r_funct_ok)) ||
                     is_lui || is_auipc || is_jal || is_jalr;

  always_comb begin
    case (func3)
      3'd0:    alu_op = (inst[30] && (is_op || is_op_32)) ? ALU_SUB : ALU_ADD;
      3'd1:    alu_op = ALU_SLL;
      3'd2:    alu_op = ALU_SLT;
      3'd3:    alu_op = ALU_SLTU;
      3'd4:    alu_op = ALU_XOR;
      3'd5:    alu_op = inst[30] ? ALU_SRA : ALU_SRL;
      3'd6:    alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
    // upper-immediate and link forms all add
    if (is_lui || is_auipc || is_jal || is_jalr) begin
      alu_op = ALU_ADD;
    end
  end

  always_comb begin
    br_op = BR_NONE;
    if (is_branch) begin
      case (func3)
        3'd0:    br_op = BR_EQ;
        3'd1:    br_op = BR_NE;
        3'd4:    br_op = BR_LT;
        3'd5:    br_op = BR_GE;
        3'd6:    br_op = BR_LTU;
        3'd7:    br_op = BR_GEU;
        default: br_op = BR_NONE;
      endcase
    end
  end

  always_comb begin
    ctrl.rd_w_ena    = inst_valid && supported && (rd != 5'd0);
    ctrl.rd_w_addr   = rd;
    ctrl.alu_op      = alu_op;
    ctrl.is_word_opt = is_op_32 || is_op_imm_32;
    ctrl.br_op       = inst_valid ? br_op : BR_NONE;
    ctrl.is_jal      = inst_valid && is_jal;
    ctrl.is_jalr     = inst_valid && is_jalr;
  end

  // operand mux, default is rs1 with the I-immediate
  always_comb begin
    exe_op1 = r_data1;
    exe_op2 = imm_i;
    if (is_op || is_op_32 || is_branch) begin
      exe_op2 = r_data2;
    end else if (is_lui) begin
      exe_op1 = '0;
      exe_op2 = imm_u;
    end else if (is_auipc) begin
      exe_op1 = inst_addr;
      exe_op2 = imm_u;
    end else if (is_jal || is_jalr) begin
      // link value pc + 4
      exe_op1 = inst_addr;
      exe_op2 = 64'd4;
    end
  end

  assign jmp_imm     = is_branch ? imm_b : (is_jal ? imm_j : '0);
  assign jalr_sum    = r_data1 + imm_i;
  assign jalr_target = {jalr_sum[XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

/* source/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

/* 31 x 64-bit registers, two combinational reads, one write at the clock edge
   x0 is not stored and always reads zero */

module regfile (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [4:0]                   rs1_r_addr,
  input  logic [4:0]                   rs2_r_addr,
  output logic [rv_core_pkg::XLEN-1:0] r_data1,
  output logic [rv_core_pkg::XLEN-1:0] r_data2,
  input  rv_core_pkg::wb_t             wb
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.ena && (wb.addr != 5'd0)) begin
      regs[wb.addr] <= wb.data;
    end
  end

  assign r_data1 = (rs1_r_addr == 5'd0) ? '0 : regs[rs1_r_addr];
  assign r_data2 = (rs2_r_addr == 5'd0) ? '0 : regs[rs2_r_addr];

  // decode never requests a write to x0
  assert property (@(posedge clk) disable iff (!arst_n) wb.ena |-> (wb.addr != 5'd0))
    else $error("regfile: write enable with x0 destination");

endmodule

`default_nettype wire

/* source/exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

/* RV64I ALU and branch compare; word forms return bit 31 sign extended
   branch conditions use the raw register values, not the ALU operands */

module exe_stage (
  input  rv_core_pkg::dec_ctrl_t       ctrl,
  input  logic [rv_core_pkg::XLEN-1:0] exe_op1,
  input  logic [rv_core_pkg::XLEN-1:0] exe_op2,
  input  logic [rv_core_pkg::XLEN-1:0] r_data1,
  input  logic [rv_core_pkg::XLEN-1:0] r_data2,
  output logic [rv_core_pkg::XLEN-1:0] alu_result,
  output logic                         br_taken
);
  import rv_core_pkg::*;

  logic [5:0]      shamt;
  logic [XLEN-1:0] shift_src;
  logic [XLEN-1:0] alu_raw;

  // word shifts take 5 bits of shift amount
  assign shamt = ctrl.is_word_opt ? {1'b0, exe_op2[4:0]} : exe_op2[5:0];

  // low word extended first so right shifts pull in the right bits
  always_comb begin
    shift_src = exe_op1;
    if (ctrl.is_word_opt) begin
      if (ctrl.alu_op == ALU_SRA) begin
        shift_src = {{32{exe_op1[31]}}, exe_op1[31:0]};
      end else begin
        shift_src = {32'b0, exe_op1[31:0]};
      end
    end
  end

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_raw = exe_op1 + exe_op2;
      ALU_SUB:  alu_raw = exe_op1 - exe_op2;
      ALU_SLT:  alu_raw = {{(XLEN-1){1'b0}}, $signed(exe_op1) < $signed(exe_op2)};
      ALU_SLTU: alu_raw = {{(XLEN-1){1'b0}}, exe_op1 < exe_op2};
      ALU_XOR:  alu_raw = exe_op1 ^ exe_op2;
      ALU_OR:   alu_raw = exe_op1 | exe_op2;
      ALU_AND:  alu_raw = exe_op1 & exe_op2;
      ALU_SLL:  alu_raw = exe_op1 << shamt;
      ALU_SRL:  alu_raw = shift_src >> shamt;
      ALU_SRA:  alu_raw = $signed(shift_src) >>> shamt;
      default:  alu_raw = '0;
    endcase
  end

  assign alu_result = ctrl.is_word_opt ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  always_comb begin
    case (ctrl.br_op)
      BR_EQ:   br_taken = (r_data1 == r_data2);
      BR_NE:   br_taken = (r_data1 != r_data2);
      BR_LT:   br_taken = ($signed(r_data1) < $signed(r_data2));
      BR_GE:   br_taken = ($signed(r_data1) >= $signed(r_data2));
      BR_LTU:  br_taken = (r_data1 < r_data2);
      BR_GEU:  br_taken = (r_data1 >= r_data2);
      default: br_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* source/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

/* pc register, updated at every edge that samples a valid instruction
   no misaligned-target trap, the pc is expected to stay word aligned */

module pc_gen (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         inst_valid,
  input  rv_core_pkg::dec_ctrl_t       ctrl,
  input  logic                         br_taken,
  input  logic [rv_core_pkg::XLEN-1:0] jmp_imm,
  input  logic [rv_core_pkg::XLEN-1:0] jalr_target,
  output logic [rv_core_pkg::XLEN-1:0] pc
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] pc_next;

  // branch/jal relative, jalr absolute, else sequential
  always_comb begin
    if (br_taken || ctrl.is_jal) begin
      pc_next = pc + jmp_imm;
    end else if (ctrl.is_jalr) begin
      pc_next = jalr_target;
    end else if (inst_valid) begin
      pc_next = pc + 64'd4;
    end else begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
    else $error("pc_gen: pc not word aligned, pc=%h", pc);

endmodule

`default_nettype wire

/* source/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

/* single-cycle RV64I slice; inst must be the instruction at pc on a valid cycle
   wb shows the write that lands at the next rising edge */

module rv_core_top (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [31:0]                  inst,
  input  logic                         inst_valid,
  output logic [rv_core_pkg::XLEN-1:0] pc,
  output rv_core_pkg::wb_t             wb
);
  import rv_core_pkg::*;

  logic [4:0]      rs1_r_addr;
  logic [4:0]      rs2_r_addr;
  logic [XLEN-1:0] r_data1;
  logic [XLEN-1:0] r_data2;
  dec_ctrl_t       ctrl;
  logic [XLEN-1:0] exe_op1;
  logic [XLEN-1:0] exe_op2;
  logic [XLEN-1:0] jmp_imm;
  logic [XLEN-1:0] jalr_target;
  logic [XLEN-1:0] alu_result;
  logic            br_taken;

  id_stage id_stage_inst (
    .inst        (inst),
    .inst_valid  (inst_valid),
    .inst_addr   (pc),
    .r_data1     (r_data1),
    .r_data2     (r_data2),
    .rs1_r_addr  (rs1_r_addr),
    .rs2_r_addr  (rs2_r_addr),
    .ctrl        (ctrl),
    .exe_op1     (exe_op1),
    .exe_op2     (exe_op2),
    .jmp_imm     (jmp_imm),
    .jalr_target (jalr_target)
  );

  regfile regfile_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .rs1_r_addr (rs1_r_addr),
    .rs2_r_addr (rs2_r_addr),
    .r_data1    (r_data1),
    .r_data2    (r_data2),
    .wb         (wb)
  );

  exe_stage exe_stage_inst (
    .ctrl       (ctrl),
    .exe_op1    (exe_op1),
    .exe_op2    (exe_op2),
    .r_data1    (r_data1),
    .r_data2    (r_data2),
    .alu_result (alu_result),
    .br_taken   (br_taken)
  );

  pc_gen pc_gen_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .inst_valid  (inst_valid),
    .ctrl        (ctrl),
    .br_taken    (br_taken),
    .jmp_imm     (jmp_imm),
    .jalr_target (jalr_target),
    .pc          (pc)
  );

  // every result goes through the ALU, including the jump link value
  assign wb = '{ena: ctrl.rd_w_ena, addr: ctrl.rd_w_addr, data: alu_result};

endmodule

`default_nettype wire

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

/* one instruction per cycle, checked against a model at the falling edge
   only valid encodings of the supported opcodes are generated as ALU work */

module rv_core_tb;
  import rv_core_pkg::*;

  logic            clk;
  logic            arst_n;
  logic [31:0]     inst;
  logic            inst_valid;
  logic [XLEN-1:0] pc;
  wb_t             wb;

  // architectural model, owned by the compare process
  logic [XLEN-1:0] m_regs [0:31] = '{default: '0};
  logic [XLEN-1:0] m_pc = RESET_PC;
  wb_t             exp_wb;
  logic [XLEN-1:0] exp_pc;
  integer          seed;
  int              errors;
  int              cmp_errors;
  int              checks;
  int              tests;
  int              wait_cycles;

  rv_core_top rv_core_top_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst       (inst),
    .inst_valid (inst_valid),
    .pc         (pc),
    .wb         (wb)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
      input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // x1..x16, x31 stays free as a scratch register
  function automatic logic [4:0] pick_reg(input logic [31:0] r);
    return {1'b0, r[3:0]} + 5'd1;
  endfunction

  function automatic logic [63:0] alu_full(input logic [2:0] f3, input logic alt,
      input logic [63:0] x, input logic [63:0] y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[5:0];
      3'd2:    return {63'd0, $signed(x) < $signed(y)};
      3'd3:    return {63'd0, x < y};
      3'd4:    return x ^ y;
      3'd5: begin
        if (alt) return $signed(x) >>> y[5:0];
        return x >> y[5:0];
      end
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic [63:0] alu_word(input logic [2:0] f3, input logic alt,
      input logic [63:0] x, input logic [63:0] y);
    logic [31:0] lo;
    case (f3)
      3'd1:    lo = x[31:0] << y[4:0];
      3'd5: begin
        if (alt) lo = $signed(x[31:0]) >>> y[4:0];
        else lo = x[31:0] >> y[4:0];
      end
      default: lo = alt ? x[31:0] - y[31:0] : x[31:0] + y[31:0];
    endcase
    return {{32{lo[31]}}, lo};
  endfunction

  function automatic void ref_step(input logic [31:0] i, output wb_t w,
      output logic [63:0] npc);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [63:0] r;
    logic [2:0]  f3;
    logic        wr;
    logic        take;
    a     = m_regs[i[19:15]];
    b     = m_regs[i[24:20]];
    f3    = i[14:12];
    imm_i = {{52{i[31]}}, i[31:20]};
    imm_u = {{32{i[31]}}, i[31:12], 12'h000};
    // jumps link pc + 4
    r     = m_pc + 64'd4;
    npc   = m_pc + 64'd4;
    wr    = 1'b1;
    take  = 1'b0;
    case (i[6:0])
      OPC_OP_IMM:    r = alu_full(f3, i[30] && (f3 == 3'd5), a, imm_i);
      OPC_OP:        r = alu_full(f3, i[30], a, b);
      OPC_OP_IMM_32: r = alu_word(f3, i[30] && (f3 == 3'd5), a, imm_i);
      OPC_OP_32:     r = alu_word(f3, i[30], a, b);
      OPC_LUI:       r = imm_u;
      OPC_AUIPC:     r = m_pc + imm_u;
      OPC_JAL:       npc = m_pc + {{43{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
      OPC_JALR:      npc = (a + imm_i) & ~64'd1;
      OPC_BRANCH: begin
        wr = 1'b0;
        case (f3)
          3'd0:    take = (a == b);
          3'd1:    take = (a != b);
          3'd4:    take = ($signed(a) < $signed(b));
          3'd5:    take = ($signed(a) >= $signed(b));
          3'd6:    take = (a < b);
          default: take = (a >= b);
        endcase
        if (take) npc = m_pc + {{51{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
      end
      // loads, stores, fence and system
      default:       wr = 1'b0;
    endcase
    w.ena  = wr && (i[11:7] != 5'd0);
    w.addr = i[11:7];
    w.data = r;
  endfunction

  // compare before the edge that retires the instruction, then step the model
  always @(negedge clk) begin
    if (arst_n) begin
      exp_wb = '0;
      exp_pc = m_pc;
      if (inst_valid) ref_step(inst, exp_wb, exp_pc);
      checks++;
      if (pc !== m_pc) begin
        $display("** Error: pc expected %h, got %h", m_pc, pc);
        cmp_errors++;
      end
      if (wb.ena !== exp_wb.ena) begin
        $display("** Error: wb.ena expected %h, got %h (inst %h)", exp_wb.ena, wb.ena, inst);
        cmp_errors++;
      end
      if (exp_wb.ena && (wb.addr !== exp_wb.addr)) begin
        $display("** Error: wb.addr expected %h, got %h (inst %h)", exp_wb.addr, wb.addr, inst);
        cmp_errors++;
      end
      if (exp_wb.ena && (wb.data !== exp_wb.data)) begin
        $display("** Error: wb.data expected %h, got %h (inst %h)", exp_wb.data, wb.data, inst);
        cmp_errors++;
      end
      if (exp_wb.ena) m_regs[exp_wb.addr] = exp_wb.data;
      m_pc = exp_pc;
    end
  end

  task automatic issue(input logic [31:0] i);
    @(posedge clk);
    inst       <= i;
    inst_valid <= 1'b1;
  endtask

  // random garbage on inst while invalid
  task automatic idle(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = $random(seed);
      @(posedge clk);
      inst       <= r;
      inst_valid <= 1'b0;
    end
  endtask

  // full 64-bit random value, x31 as scratch
  task automatic load_value(input logic [4:0] rd);
    logic [31:0] a;
    logic [31:0] b;
    a = $random(seed);
    b = $random(seed);
    issue(u_type(a[19:0], rd, OPC_LUI));
    issue(i_type(a[31:20], rd, 3'd0, rd, OPC_OP_IMM));
    issue(i_type(12'd32, rd, 3'd1, rd, OPC_OP_IMM));
    issue(u_type(b[19:0], 5'd31, OPC_LUI));
    issue(i_type(b[31:20], 5'd31, 3'd0, 5'd31, OPC_OP_IMM));
    issue(r_type(7'h00, 5'd31, rd, 3'd4, rd, OPC_OP));
  endtask

  task automatic finish_test(input string name, input int e0);
    idle(2);
    tests++;
    $display("test %s: %0d errors", name, errors + cmp_errors - e0);
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors + cmp_errors;
    @(negedge clk);
    if (pc !== RESET_PC) begin
      $display("** Error: pc expected %h, got %h", RESET_PC, pc);
      errors++;
    end
    if (wb.ena !== 1'b0) begin
      $display("** Error: wb.ena expected 0, got %h", wb.ena);
      errors++;
    end
    idle(4);
    @(negedge clk);
    if (pc !== RESET_PC) begin
      $display("** Error: pc expected %h after idle cycles, got %h", RESET_PC, pc);
      errors++;
    end
    finish_test("reset_state", e0);
  endtask

  task automatic test_alu();
    int          e0;
    logic [31:0] r;
    logic [31:0] s;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    e0 = errors + cmp_errors;
    for (int k = 1; k <= 16; k++) begin
      load_value(k[4:0]);
    end
    r = $random(seed);
    issue(u_type(r[19:0], 5'd7, OPC_AUIPC));
    for (int k = 0; k < 200; k++) begin
      if (k % 10 == 9) load_value(pick_reg(r));
      r  = $random(seed);
      s  = $random(seed);
      f3 = r[2:0];
      if (r[3]) begin
        f7 = (((f3 == 3'd0) || (f3 == 3'd5)) && r[4]) ? 7'h20 : 7'h00;
        issue(r_type(f7, pick_reg(s), pick_reg(s >> 8), f3, pick_reg(s >> 16), OPC_OP));
      end else begin
        imm = s[31:20];
        // shift immediates carry a 6-bit shamt
        if (f3 == 3'd1) imm = {6'h00, s[25:20]};
        if (f3 == 3'd5) imm = {r[4] ? 6'h10 : 6'h00, s[25:20]};
        issue(i_type(imm, pick_reg(s >> 8), f3, pick_reg(s >> 16), OPC_OP_IMM));
      end
    end
    finish_test("alu_ops", e0);
  endtask

  task automatic test_word();
    int          e0;
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    e0 = errors + cmp_errors;
    r  = $random(seed);
    for (int k = 0; k < 100; k++) begin
      if (k % 10 == 9) load_value(pick_reg(r));
      r   = $random(seed);
      s   = $random(seed);
      rs1 = pick_reg(s);
      rs2 = pick_reg(s >> 4);
      rd  = pick_reg(s >> 8);
      case (r[2:0])
        3'd0:    issue(r_type(7'h00, rs2, rs1, 3'd0, rd, OPC_OP_32));
        3'd1:    issue(r_type(7'h20, rs2, rs1, 3'd0, rd, OPC_OP_32));
        3'd2:    issue(r_type(7'h00, rs2, rs1, 3'd1, rd, OPC_OP_32));
        3'd3:    issue(r_type(7'h00, rs2, rs1, 3'd5, rd, OPC_OP_32));
        3'd4:    issue(r_type(7'h20, rs2, rs1, 3'd5, rd, OPC_OP_32));
        default: issue(i_type(s[31:20], rs1, 3'd0, rd, OPC_OP_IMM_32));
      endcase
    end
    finish_test("word_ops", e0);
  endtask

  task automatic test_branch();
    int          e0;
    logic [31:0] r;
    logic [2:0]  f3;
    e0 = errors + cmp_errors;
    for (int t = 0; t < 8; t++) begin
      f3 = t[2:0];
      if ((f3 != 3'd2) && (f3 != 3'd3)) begin
        load_value(5'd10);
        load_value(5'd11);
        r = $random(seed);
        // swapped and equal operands give both outcomes for every type
        issue(b_type({r[12:2], 2'b00}, 5'd11, 5'd10, f3));
        issue(b_type({r[22:12], 2'b00}, 5'd10, 5'd11, f3));
        issue(b_type({r[31:21], 2'b00}, 5'd10, 5'd10, f3));
      end
    end
    finish_test("branches", e0);
  endtask

  task automatic test_jump();
    int          e0;
    logic [31:0] r;
    logic [31:0] s;
    e0 = errors + cmp_errors;
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      s = $random(seed);
      issue(j_type({r[31:13], 2'b00}, pick_reg(s)));
      // odd base, so the target only aligns once bit 0 is cleared
      issue(u_type(r[19:0], 5'd12, OPC_LUI));
      issue(i_type({s[31:22], 2'b01}, 5'd12, 3'd0, 5'd12, OPC_OP_IMM));
      issue(i_type({s[19:10], 2'b00}, 5'd12, 3'd0, k[0] ? 5'd12 : 5'd9, OPC_JALR));
    end
    finish_test("jumps", e0);
  endtask

  task automatic test_no_write();
    int          e0;
    logic [31:0] r;
    e0 = errors + cmp_errors;
    for (int k = 0; k < 4; k++) begin
      r = $random(seed);
      issue(i_type(r[11:0], 5'd1, 3'd3, 5'd5, 7'h03));
      // sd x2, 8(x1)
      issue(r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd8, 7'h23));
      issue(32'h0ff0_000f);
      issue(32'h0000_0073);
      issue(i_type(12'h300, 5'd1, 3'd1, 5'd5, 7'h73));
      issue(i_type(r[23:12], 5'd1, 3'd0, 5'd0, OPC_OP_IMM));
      issue(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, OPC_OP));
      issue(u_type(r[31:12], 5'd0, OPC_LUI));
      issue(j_type({r[20:2], 2'b00}, 5'd0));
      // x0 as a source
      issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd13, OPC_OP));
      issue(r_type(7'h00, 5'd0, 5'd1, 3'd6, 5'd14, OPC_OP));
    end
    finish_test("no_write", e0);
  endtask

  initial begin
    seed        = 32'hc3b;
    arst_n      = 1'b0;
    // jal x1 +8 sits on inst while invalid, so it must neither write nor jump
    inst        = 32'h0080_00ef;
    inst_valid  = 1'b0;
    errors      = 0;
    tests       = 0;
    wait_cycles = 0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    while ((pc !== RESET_PC) && (wait_cycles < 16)) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (wait_cycles >= 16) begin
      $display("reset release: pc never reached its reset value");
      errors++;
    end
    test_reset();
    test_alu();
    test_word();
    test_branch();
    test_jump();
    test_no_write();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors + cmp_errors);
    if (errors + cmp_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #100_000;
    $display("timeout: the run did not complete in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
source/rv_core_pkg.sv
source/id_stage.sv
source/regfile.sv
source/exe_stage.sv
source/pc_gen.sv
source/rv_core_top.sv
verif/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build the rv_core testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary -f all.f --top-module rv_core_tb -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"
